// File: logic/sdramGeomPkg.sv
// Address, data, bank and array geometry constants and types
`default_nettype none

package sdramGeomPkg;

    // Pin widths
    localparam int addrBits = 13;
    localparam int dataBits = 16;
    localparam int bankBits = 2;
    localparam int maskBits = 2;

    // Reduced array, only the low row and column bits are stored
    localparam int rowUsedBits = 3;
    localparam int colUsedBits = 5;
    localparam int numBanks    = 2 ** bankBits;
    localparam int memDepth    = 2 ** (rowUsedBits + colUsedBits);

    typedef logic [addrBits-1:0]    addrWordT;
    typedef logic [dataBits-1:0]    dataWordT;
    typedef logic [bankBits-1:0]    bankT;
    typedef logic [rowUsedBits-1:0] rowT;
    typedef logic [colUsedBits-1:0] colT;
    typedef logic [maskBits-1:0]    maskT;

endpackage

`default_nettype wire

// File: logic/sdramCmdPkg.sv
// Command codes, mode register fields and the decoded views of the address word
`default_nettype none

package sdramCmdPkg;
    import sdramGeomPkg::*;

    typedef enum logic [2:0] {
        cmdNop,
        cmdActive,
        cmdRead,
        cmdWrite,
        cmdPrecharge,
        cmdLoadMode
    } cmdT;

    typedef logic [2:0] burstLenT;
    typedef logic [2:0] casLatT;

    // Mode register layout, A12..A0
    typedef struct packed {
        logic [5:0] opMode;
        casLatT     casLat;
        logic       burstType;
        burstLenT   burstLen;
    } modeFieldsT;

    // Activate view
    typedef struct packed {
        logic [addrBits-rowUsedBits-1:0] rowHigh;
        rowT                             row;
    } rowViewT;

    // Read, write and precharge view, A10 selects all banks
    typedef struct packed {
        logic [1:0]                         topBits;
        logic                               allBanks;
        logic [addrBits-colUsedBits-4:0]    colHigh;
        colT                                col;
    } colViewT;

    typedef union packed {
        modeFieldsT mode;
        rowViewT    rowView;
        colViewT    colView;
    } addrUnionT;

    // Burst length and CAS latency codes
    localparam burstLenT burstLen1 = 3'd0;
    localparam burstLenT burstLen2 = 3'd1;
    localparam burstLenT burstLen4 = 3'd2;
    localparam burstLenT burstLen8 = 3'd3;
    localparam casLatT   casLat2   = 3'd2;
    localparam int       maxCasLat = 3;

    localparam modeFieldsT modeReset = '{
        opMode:    6'd0,
        casLat:    casLat2,
        burstType: 1'b0,
        burstLen:  burstLen1
    };

endpackage

`default_nettype wire

// File: logic/sdramIfs.sv
// Command bus and beat bus interfaces of the SDRAM model
`timescale 1ns/100ps
`default_nettype none

// **************************************************************************
// Decoded command, same cycle as the pins
// **************************************************************************
interface sdramCmdIf import sdramGeomPkg::*, sdramCmdPkg::*; ();

    cmdT        cmd;
    bankT       bank;
    addrUnionT  addr;
    // Current mode register contents
    modeFieldsT mode;

    modport decoder (
        output cmd,
        output bank,
        output addr,
        output mode
    );

    modport consumer (
        input cmd,
        input bank,
        input addr,
        input mode
    );

endinterface

// **************************************************************************
// One word access per asserted beat, taken at the next edge
// **************************************************************************
interface sdramBeatIf import sdramGeomPkg::*; ();

    logic rdBeat;
    logic wrBeat;
    bankT bank;
    colT  col;
    maskT rdMask;

    modport engine (
        output rdBeat,
        output wrBeat,
        output bank,
        output col,
        output rdMask
    );

    modport datapath (
        input rdBeat,
        input wrBeat,
        input bank,
        input col,
        input rdMask
    );

endinterface

`default_nettype wire

// File: logic/sdramCmdDecoder.sv
// Command pin decoder and mode register
`timescale 1ns/100ps
`default_nettype none

module sdramCmdDecoder import sdramGeomPkg::*, sdramCmdPkg::*; (
    input  logic        Clk,
    input  logic        rstN,
    input  logic        csN,
    input  logic        rasN,
    input  logic        casN,
    input  logic        weN,
    input  bankT        ba,
    input  addrWordT    addr,
    sdramCmdIf.decoder  cmdBus
);

    addrUnionT  addrView;
    modeFieldsT modeReg;

    assign addrView    = addr;
    assign cmdBus.addr = addrView;
    assign cmdBus.bank = ba;
    assign cmdBus.mode = modeReg;

    // RAS, CAS, WE truth table
    always_comb begin
        cmdBus.cmd = cmdNop;
        if (!csN) begin
            case ({rasN, casN, weN})
                3'b011:  cmdBus.cmd = cmdActive;
                3'b101:  cmdBus.cmd = cmdRead;
                3'b100:  cmdBus.cmd = cmdWrite;
                3'b010:  cmdBus.cmd = cmdPrecharge;
                3'b000:  cmdBus.cmd = cmdLoadMode;
                // Auto refresh and burst terminate land here
                default: cmdBus.cmd = cmdNop;
            endcase
        end
    end

    always_ff @(posedge Clk or negedge rstN) begin
        if (!rstN) begin
            modeReg <= modeReset;
        end else if (cmdBus.cmd == cmdLoadMode) begin
            modeReg <= addrView.mode;
        end
    end

endmodule

`default_nettype wire

// File: logic/sdramBankTracker.sv
// Per-bank open state and row address table
`timescale 1ns/100ps
`default_nettype none

module sdramBankTracker import sdramGeomPkg::*, sdramCmdPkg::*; (
    input  logic                Clk,
    input  logic                rstN,
    sdramCmdIf.consumer         cmdBus,
    output logic [numBanks-1:0] openMask,
    output rowT [numBanks-1:0]  rowTable
);

    logic isActive;
    logic isPrecharge;

    assign isActive    = (cmdBus.cmd == cmdActive);
    assign isPrecharge = (cmdBus.cmd == cmdPrecharge);

    // Open flags
    always_ff @(posedge Clk or negedge rstN) begin
        if (!rstN) begin
            openMask <= '0;
        end else if (isActive) begin
            openMask[cmdBus.bank] <= 1'b1;
        end else if (isPrecharge) begin
            if (cmdBus.addr.colView.allBanks) begin
                openMask <= '0;
            end else begin
                openMask[cmdBus.bank] <= 1'b0;
            end
        end
    end

    // Row latched on activate, only meaningful while the bank is open
    always_ff @(posedge Clk) begin
        if (isActive) begin
            rowTable[cmdBus.bank] <= cmdBus.addr.rowView.row;
        end
    end

endmodule

`default_nettype wire

// File: logic/sdramBurstEngine.sv
// CAS latency pipeline, burst counter and column sequencing
`timescale 1ns/100ps
`default_nettype none

module sdramBurstEngine import sdramGeomPkg::*, sdramCmdPkg::*; (
    input  logic         Clk,
    input  logic         rstN,
    sdramCmdIf.consumer  cmdBus,
    input  maskT         dqm,
    sdramBeatIf.engine   beat
);

    // Read CAS pipeline, reads launch from stage 0
    logic [maxCasLat-2:0] pipeValid;
    bankT                 pipeBank [maxCasLat-1];
    colT                  pipeCol  [maxCasLat-1];
    int unsigned          entryIdx;

    logic       isRead;
    logic       isWrite;
    logic       launchRd;
    logic       burstOn;
    logic [2:0] beatCnt;
    logic [2:0] nextCnt;
    logic [2:0] lastBeat;
    logic [2:0] modeLast;
    logic [2:0] offset;
    logic       interleave;
    colT        startCol;
    colT        nextCol;
    maskT       dqmQ;

    assign isRead   = (cmdBus.cmd == cmdRead);
    assign isWrite  = (cmdBus.cmd == cmdWrite);
    assign launchRd = pipeValid[0];
    assign burstOn  = beat.rdBeat | beat.wrBeat;
    assign entryIdx = (cmdBus.mode.casLat == casLatT'(maxCasLat)) ? maxCasLat - 2 : 0;

    // Last beat index doubles as the wrap mask
    always_comb begin
        case (cmdBus.mode.burstLen)
            burstLen2: modeLast = 3'd1;
            burstLen4: modeLast = 3'd3;
            burstLen8: modeLast = 3'd7;
            default:   modeLast = 3'd0;
        endcase
    end

    // Next column within the burst block
    assign nextCnt = beatCnt + 3'd1;
    assign offset  = interleave ? (startCol[2:0] ^ nextCnt) : (startCol[2:0] + nextCnt);
    assign nextCol = {startCol[4:3], (startCol[2:0] & ~lastBeat) | (offset & lastBeat)};

    // **********************************************************************
    // Burst control
    // **********************************************************************
    always_ff @(posedge Clk or negedge rstN) begin
        if (!rstN) begin
            pipeValid   <= '0;
            beat.rdBeat <= 1'b0;
            beat.wrBeat <= 1'b0;
            beatCnt     <= '0;
            lastBeat    <= '0;
            interleave  <= 1'b0;
        end else begin
            pipeValid <= pipeValid >> 1;
            if (isRead) begin
                pipeValid[entryIdx] <= 1'b1;
            end
            // A new write wins over a read leaving the pipeline
            if (isWrite || launchRd) begin
                beat.wrBeat <= isWrite;
                beat.rdBeat <= !isWrite;
                beatCnt     <= '0;
                lastBeat    <= modeLast;
                interleave  <= cmdBus.mode.burstType;
            end else if (burstOn && beatCnt != lastBeat) begin
                beatCnt <= nextCnt;
            end else begin
                beat.rdBeat <= 1'b0;
                beat.wrBeat <= 1'b0;
            end
        end
    end

    // Addresses and read mask
    always_ff @(posedge Clk) begin
        for (int i = 0; i < maxCasLat - 2; i++) begin
            pipeBank[i] <= pipeBank[i+1];
            pipeCol[i]  <= pipeCol[i+1];
        end
        if (isRead) begin
            pipeBank[entryIdx] <= cmdBus.bank;
            pipeCol[entryIdx]  <= cmdBus.addr.colView.col;
        end
        // Two stages here plus the output register give the DQM read latency
        dqmQ        <= dqm;
        beat.rdMask <= dqmQ;
        if (isWrite) begin
            beat.bank <= cmdBus.bank;
            beat.col  <= cmdBus.addr.colView.col;
            startCol  <= cmdBus.addr.colView.col;
        end else if (launchRd) begin
            beat.bank <= pipeBank[0];
            beat.col  <= pipeCol[0];
            startCol  <= pipeCol[0];
        end else if (burstOn) begin
            beat.col <= nextCol;
        end
    end

endmodule

`default_nettype wire

// File: logic/sdramDataPath.sv
// Memory array, byte masking, read output register and illegal access flag
`timescale 1ns/100ps
`default_nettype none

module sdramDataPath import sdramGeomPkg::*; (
    input  logic                Clk,
    input  logic                rstN,
    sdramBeatIf.datapath        beat,
    input  logic [numBanks-1:0] openMask,
    input  rowT [numBanks-1:0]  rowTable,
    input  dataWordT            dqIn,
    input  maskT                dqm,
    output dataWordT            dqOut,
    output maskT                dqOe,
    output logic                illegalAccess
);

    dataWordT mem [numBanks*memDepth];
    dataWordT dqInQ;
    maskT     wrMaskQ;
    logic     bankOpen;
    logic [bankBits+rowUsedBits+colUsedBits-1:0] memIdx;

    assign bankOpen = openMask[beat.bank];
    assign memIdx   = {beat.bank, rowTable[beat.bank], beat.col};

    // Write data and mask of the edge that issued the beat
    always_ff @(posedge Clk) begin
        dqInQ   <= dqIn;
        wrMaskQ <= dqm;
    end

    // Byte lane writes, masked lanes keep the stored byte
    always_ff @(posedge Clk) begin
        if (beat.wrBeat && bankOpen) begin
            for (int b = 0; b < maskBits; b++) begin
                if (!wrMaskQ[b]) begin
                    mem[memIdx][b*8 +: 8] <= dqInQ[b*8 +: 8];
                end
            end
        end
    end

    always_ff @(posedge Clk) begin
        if (beat.rdBeat) begin
            dqOut <= mem[memIdx];
        end
    end

    // Output enables and closed bank flag
    always_ff @(posedge Clk or negedge rstN) begin
        if (!rstN) begin
            dqOe          <= '0;
            illegalAccess <= 1'b0;
        end else begin
            dqOe          <= (beat.rdBeat && bankOpen) ? ~beat.rdMask : '0;
            illegalAccess <= (beat.rdBeat || beat.wrBeat) && !bankOpen;
        end
    end

endmodule

`default_nettype wire

// File: logic/sdramModel.sv
// SDRAM model top level with pin ports, internal buses and block instances
`timescale 1ns/100ps
`default_nettype none

module sdramModel import sdramGeomPkg::*; (
    input  logic     Clk,
    input  logic     rstN,
    input  logic     csN,
    input  logic     rasN,
    input  logic     casN,
    input  logic     weN,
    input  bankT     ba,
    input  addrWordT addr,
    input  maskT     dqm,
    input  dataWordT dqIn,
    output dataWordT dqOut,
    output maskT     dqOe,
    output logic     illegalAccess
);

    sdramCmdIf  cmdBus ();
    sdramBeatIf beatBus ();

    logic [numBanks-1:0] openMask;
    rowT [numBanks-1:0]  rowTable;

    sdramCmdDecoder sdramCmdDecoder_i (
        .Clk    (Clk),
        .rstN   (rstN),
        .csN    (csN),
        .rasN   (rasN),
        .casN   (casN),
        .weN    (weN),
        .ba     (ba),
        .addr   (addr),
        .cmdBus (cmdBus)
    );

    // Bank state and burst sequencing run side by side
    sdramBankTracker sdramBankTracker_i (
        .Clk      (Clk),
        .rstN     (rstN),
        .cmdBus   (cmdBus),
        .openMask (openMask),
        .rowTable (rowTable)
    );

    sdramBurstEngine sdramBurstEngine_i (
        .Clk    (Clk),
        .rstN   (rstN),
        .cmdBus (cmdBus),
        .dqm    (dqm),
        .beat   (beatBus)
    );

    sdramDataPath sdramDataPath_i (
        .Clk           (Clk),
        .rstN          (rstN),
        .beat          (beatBus),
        .openMask      (openMask),
        .rowTable      (rowTable),
        .dqIn          (dqIn),
        .dqm           (dqm),
        .dqOut         (dqOut),
        .dqOe          (dqOe),
        .illegalAccess (illegalAccess)
    );

endmodule

`default_nettype wire

// File: tests/sdramModelSva.sv
// Concurrent assertions on the SDRAM model pins, bound to the top level
`timescale 1ns/100ps
`default_nettype none

module sdramModelSva import sdramGeomPkg::*; (
    input logic Clk,
    input logic rstN,
    input logic csN,
    input logic rasN,
    input logic casN,
    input logic weN,
    input maskT dqOe,
    input logic illegalAccess
);

    logic       readCmd;
    logic [3:0] sinceRead;

    assign readCmd = !csN && rasN && !casN && weN;

    // Cycles since the last READ, saturating
    always_ff @(posedge Clk or negedge rstN) begin
        if (!rstN) begin
            sinceRead <= 4'hf;
        end else if (readCmd) begin
            sinceRead <= 4'h0;
        end else if (sinceRead != 4'hf) begin
            sinceRead <= sinceRead + 4'h1;
        end
    end

    oeLowInReset: assert property (@(posedge Clk) !rstN |-> dqOe == '0)
        else $error("dqOe active while reset is asserted");

    oeAfterRead: assert property (@(posedge Clk) disable iff (!rstN)
        dqOe != '0 |-> sinceRead <= 4'd11)
        else $error("dqOe active more than 11 cycles after a READ");

    noOeOnIllegal: assert property (@(posedge Clk) disable iff (!rstN)
        !(illegalAccess && dqOe != '0))
        else $error("dqOe driven on a closed bank beat");

endmodule

bind sdramModel sdramModelSva sdramModelSva_i (
    .Clk           (Clk),
    .rstN          (rstN),
    .csN           (csN),
    .rasN          (rasN),
    .casN          (casN),
    .weN           (weN),
    .dqOe          (dqOe),
    .illegalAccess (illegalAccess)
);

`default_nettype wire

// File: tests/sdramModelTb.sv
// Testbench for the SDRAM model with file-driven stimulus, read checks and a watchdog
`timescale 1ns/100ps
`default_nettype none

module sdramModelTb import sdramGeomPkg::*; ();

    logic     Clk;
    logic     rstN;
    logic     csN;
    logic     rasN;
    logic     casN;
    logic     weN;
    bankT     ba;
    addrWordT addr;
    maskT     dqm;
    dataWordT dqIn;
    dataWordT dqOut;
    maskT     dqOe;
    logic     illegalAccess;

    // Records from the stimulus file, one per clock cycle
    string    recName [$];
    string    recOp   [$];
    bankT     recBank [$];
    addrWordT recAddr [$];
    maskT     recDqm  [$];
    dataWordT recData [$];
    maskT     recOe   [$];
    logic     recIll  [$];

    // Expected read beats, ordered by the edge that updates the outputs
    int       expDue  [$];
    dataWordT expData [$];
    maskT     expOe   [$];
    logic     expIll  [$];

    int    cycle     = 0;
    int    burstLen  = 1;
    int    casLat    = 2;
    int    beatsLeft = 0;
    int    testErrs  = 0;
    int    passCount = 0;
    int    failCount = 0;
    int    setupErrs = 0;
    int    timeLimit = 0;
    bit    running   = 1'b0;
    bit    loaded    = 1'b0;
    string curTest   = "";

    sdramModel sdramModel_i (
        .Clk           (Clk),
        .rstN          (rstN),
        .csN           (csN),
        .rasN          (rasN),
        .casN          (casN),
        .weN           (weN),
        .ba            (ba),
        .addr          (addr),
        .dqm           (dqm),
        .dqIn          (dqIn),
        .dqOut         (dqOut),
        .dqOe          (dqOe),
        .illegalAccess (illegalAccess)
    );

    initial Clk = 1'b0;
    always #5 Clk = ~Clk;

    // **********************************************************************
    // Stimulus file and pin driving
    // **********************************************************************
    task automatic loadRecords();
        int    fd;
        int    n;
        int    b, a, m, d, oe, ill;
        string line;
        string name;
        string op;
        fd = $fopen("tests/sdramInput.dat", "r");
        if (fd == 0) begin
            $display("Stimulus file tests/sdramInput.dat could not be opened");
            setupErrs++;
            return;
        end
        while (!$feof(fd)) begin
            n = $fgets(line, fd);
            if (n > 0 && line.len() > 1 && line.substr(0, 0) != "#") begin
                if ($sscanf(line, "%s %s %h %h %h %h %h %h",
                            name, op, b, a, m, d, oe, ill) == 8) begin
                    recName.push_back(name);
                    recOp.push_back(op);
                    recBank.push_back(bankT'(b));
                    recAddr.push_back(addrWordT'(a));
                    recDqm.push_back(maskT'(m));
                    recData.push_back(dataWordT'(d));
                    recOe.push_back(maskT'(oe));
                    recIll.push_back(ill[0]);
                end
            end
        end
        $fclose(fd);
    endtask

    task automatic setStrobes(input logic [2:0] rcw);
        rasN <= rcw[2];
        casN <= rcw[1];
        weN  <= rcw[0];
    endtask

    task automatic driveIdle();
        csN <= 1'b1;
        setStrobes(3'b111);
        dqm <= '0;
    endtask

    // A new burst cuts off older beats that are due after its own first beat
    task automatic dropAfter(input int lastEdge);
        while (expDue.size() > 0 && expDue[$] > lastEdge) begin
            void'(expDue.pop_back());
            void'(expData.pop_back());
            void'(expOe.pop_back());
            void'(expIll.pop_back());
        end
    endtask

    task automatic pushExpect(input int due, input int i);
        expDue.push_back(due);
        expData.push_back(recData[i]);
        expOe.push_back(recOe[i]);
        expIll.push_back(recIll[i]);
    endtask

    task automatic applyRecord(input int i);
        int cmdEdge;
        // Pins driven now are sampled at the next edge
        cmdEdge = cycle + 1;
        ba   <= recBank[i];
        addr <= recAddr[i];
        dqm  <= recDqm[i];
        dqIn <= recData[i];
        csN  <= 1'b0;
        case (recOp[i])
            "mode":  setStrobes(3'b000);
            "act":   setStrobes(3'b011);
            "rd":    setStrobes(3'b101);
            "wr":    setStrobes(3'b100);
            "pre":   setStrobes(3'b010);
            // Idle keeps the record's dqm for masks during bursts
            default: begin
                csN <= 1'b1;
                setStrobes(3'b111);
            end
        endcase
        if (recOp[i] == "mode") begin
            burstLen  = 1 << recAddr[i][2:0];
            casLat    = recAddr[i][6:4];
            beatsLeft = 0;
        end else if (recOp[i] == "rd") begin
            dropAfter(cmdEdge + casLat - 1);
            pushExpect(cmdEdge + casLat, i);
            beatsLeft = burstLen - 1;
        end else if (recOp[i] == "wr") begin
            dropAfter(cmdEdge);
            beatsLeft = 0;
        end else if (beatsLeft > 0) begin
            pushExpect(cmdEdge + casLat, i);
            beatsLeft--;
        end
    endtask

    // **********************************************************************
    // Output checks, between edges
    // **********************************************************************
    task automatic checkOutputs();
        dataWordT d;
        maskT     oe;
        logic     ill;
        if (expDue.size() > 0 && expDue[0] == cycle) begin
            void'(expDue.pop_front());
            d   = expData.pop_front();
            oe  = expOe.pop_front();
            ill = expIll.pop_front();
            if (dqOe !== oe) begin
                $display("Error %s: dqOe expected %h, actual %h", curTest, oe, dqOe);
                testErrs++;
            end
            if (oe != '0 && dqOut !== d) begin
                $display("Error %s: dqOut expected %h, actual %h", curTest, d, dqOut);
                testErrs++;
            end
            if (illegalAccess !== ill) begin
                $display("Error %s: illegalAccess expected %b, actual %b", curTest, ill,
                         illegalAccess);
                testErrs++;
            end
        end else begin
            if (dqOe !== '0) begin
                $display("Error %s: dqOe expected 0, actual %h", curTest, dqOe);
                testErrs++;
            end
            if (illegalAccess !== 1'b0) begin
                $display("Error %s: illegalAccess expected 0, actual %b", curTest,
                         illegalAccess);
                testErrs++;
            end
        end
    endtask

    always @(negedge Clk) begin
        if (running) begin
            checkOutputs();
        end
    end

    // Run idle until every expected beat is seen, then report the test
    task automatic finishTest();
        while (expDue.size() > 0) begin
            @(posedge Clk);
            cycle++;
            driveIdle();
        end
        repeat (2) begin
            @(posedge Clk);
            cycle++;
            driveIdle();
        end
        if (testErrs == 0) begin
            $display("Test %s: pass", curTest);
            passCount++;
        end else begin
            $display("Test %s: fail with %0d errors", curTest, testErrs);
            failCount++;
        end
        testErrs = 0;
    endtask

    initial begin
        csN  = 1'b1;
        rasN = 1'b1;
        casN = 1'b1;
        weN  = 1'b1;
        ba   = '0;
        addr = '0;
        dqm  = '0;
        dqIn = '0;
        rstN = 1'b0;
        loadRecords();
        timeLimit = (recName.size() * 20 + 100) * 10;
        loaded = 1'b1;
        repeat (2) @(posedge Clk);
        rstN <= 1'b1;
        running = 1'b1;
        for (int i = 0; i < recName.size(); i++) begin
            if (i == 0) begin
                curTest = recName[i];
            end else if (recName[i] != curTest) begin
                finishTest();
                curTest = recName[i];
            end
            @(posedge Clk);
            cycle++;
            applyRecord(i);
        end
        if (recName.size() > 0) begin
            finishTest();
        end
        $display("Tests passed %0d, failed %0d, setup errors %0d", passCount, failCount,
                 setupErrs);
        if (failCount == 0 && setupErrs == 0 && passCount > 0) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    end

    // Watchdog
    initial begin
        wait (loaded);
        #(timeLimit);
        $display("Timeout after %0d ns, the run did not complete", timeLimit);
        $display("TB FAILED");
        $finish;
    end

endmodule

`default_nettype wire

// File: tests/sdramInput.dat
# One record per clock: test op bank addr dqm data expOe expIll (hex)
# Read beats carry expected word, dqOe and illegalAccess; write beats carry dqIn
seq mode 0 022 0 0000 0 0
seq act 0 005 0 0000 0 0
seq wr 0 002 0 1111 0 0
seq idle 0 000 0 2222 0 0
seq idle 0 000 0 3333 0 0
seq idle 0 000 0 4444 0 0
seq rd 0 002 0 1111 3 0
seq idle 0 000 0 2222 3 0
seq idle 0 000 0 3333 3 0
seq idle 0 000 0 4444 3 0
il mode 0 03b 0 0000 0 0
il act 1 002 0 0000 0 0
il wr 1 000 0 a000 0 0
il idle 0 000 0 a001 0 0
il idle 0 000 0 a002 0 0
il idle 0 000 0 a003 0 0
il idle 0 000 0 a004 0 0
il idle 0 000 0 a005 0 0
il idle 0 000 0 a006 0 0
il idle 0 000 0 a007 0 0
il rd 1 005 0 a005 3 0
il idle 0 000 0 a004 3 0
il idle 0 000 0 a007 3 0
il idle 0 000 0 a006 3 0
il idle 0 000 0 a001 3 0
il idle 0 000 0 a000 3 0
il idle 0 000 0 a003 3 0
il idle 0 000 0 a002 3 0
mask mode 0 021 0 0000 0 0
mask wr 0 000 1 aaaa 0 0
mask idle 0 000 2 bbbb 0 0
mask rd 0 000 0 aa33 3 0
mask idle 0 000 2 44bb 1 0
bank mode 0 020 0 0000 0 0
bank act 2 001 0 0000 0 0
bank act 3 006 0 0000 0 0
bank wr 0 00a 0 0b00 0 0
bank wr 1 00a 0 1b11 0 0
bank wr 2 00a 0 2b22 0 0
bank wr 3 00a 0 3b33 0 0
bank rd 0 00a 0 0b00 3 0
bank rd 1 00a 0 1b11 3 0
bank rd 2 00a 0 2b22 3 0
bank rd 3 00a 0 3b33 3 0
intr mode 0 022 0 0000 0 0
intr rd 0 000 0 aa33 3 0
intr idle 0 000 0 44bb 3 0
intr wr 2 004 0 6001 0 0
intr idle 0 000 0 6002 0 0
intr idle 0 000 0 6003 0 0
intr idle 0 000 0 6004 0 0
intr rd 2 004 0 6001 3 0
intr idle 0 000 0 6002 3 0
intr idle 0 000 0 6003 3 0
intr idle 0 000 0 6004 3 0
pre pre 0 400 0 0000 0 0
pre rd 1 000 0 0000 0 1
pre idle 0 000 0 0000 0 1
pre idle 0 000 0 0000 0 1
pre idle 0 000 0 0000 0 1

// File: sim.f
logic/sdramGeomPkg.sv
logic/sdramCmdPkg.sv
logic/sdramIfs.sv
logic/sdramCmdDecoder.sv
logic/sdramBankTracker.sv
logic/sdramBurstEngine.sv
logic/sdramDataPath.sv
logic/sdramModel.sv
tests/sdramModelSva.sv
tests/sdramModelTb.sv
